// File: filelist.f
+incdir+rtl
rtl/vga_bus_pkg.sv
rtl/vga_video_pkg.sv
rtl/vga_slave_interface.sv
rtl/vga_write_port.sv
rtl/vga_framebuffer.sv
rtl/vga_timing.sv
rtl/vga_pixel_out.sv
rtl/vga_top.sv
tb/vga_assert.sv
tb/tb_vga_top.sv

// File: rtl/vga_bus_pkg.sv
`include "vga_defines.svh"

package vga_bus_pkg;

    // Address cycle: x in 7..0, y in 15..8
    // Data cycle: pixel in 7..0
    typedef logic [`VGA_BUS_WIDTH-1:0] bus_word_t;

    // Control byte sent with each strobe
    typedef logic [`VGA_CTRL_WIDTH-1:0] ctrl_t;

    // Slave interface FSM states, read path not implemented
    typedef enum logic [1:0] {
        ST_WAIT_FOR_ACK = 2'd0,
        ST_WRITE_WAIT   = 2'd1,
        ST_WRITE_DATA   = 2'd2,
        ST_FINISH       = 2'd3
    } slave_state_t;

endpackage

// File: rtl/vga_defines.svh
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

// Horizontal raster, in clk cycles
`define VGA_H_ACTIVE     64
`define VGA_H_FRONT      4
`define VGA_H_SYNC       8
`define VGA_H_BACK       4
`define VGA_H_TOTAL      80

// Vertical raster, in lines
`define VGA_V_ACTIVE     48
`define VGA_V_FRONT      2
`define VGA_V_SYNC       2
`define VGA_V_BACK       2
`define VGA_V_TOTAL      54

// Register bus
`define VGA_BUS_WIDTH    32
`define VGA_CTRL_WIDTH   8
`define VGA_CTRL_WE_BIT  1

// Field positions on bus_in
`define VGA_BUS_X_LSB    0
`define VGA_BUS_Y_LSB    8
`define VGA_BUS_PIX_LSB  0

// One word per visible pixel
`define VGA_FB_DEPTH     3072

`endif

// File: rtl/vga_framebuffer.sv
`include "vga_defines.svh"

module vga_framebuffer (
    input  logic                    clk,
    input  logic                    we,
    input  vga_video_pkg::fb_addr_t waddr,
    input  vga_video_pkg::pixel_t   wdata,
    input  vga_video_pkg::fb_addr_t raddr,
    output vga_video_pkg::pixel_t   rdata
);

    import vga_video_pkg::*;

    // One RGB332 word per visible pixel, row-major
    pixel_t mem [0:`VGA_FB_DEPTH-1];

    // Bus side write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Video side read, one cycle of latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: rtl/vga_pixel_out.sv
module vga_pixel_out (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  raw_hsync,
    input  logic                  raw_vsync,
    input  logic                  raw_active,
    input  vga_video_pkg::pixel_t rd_data,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  de,
    output vga_video_pkg::pixel_t rgb
);

    logic hsync_d;
    logic vsync_d;
    logic active_d;

    // Matches the one-cycle framebuffer read
    always_ff @(posedge clk) begin
        if (reset) begin
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
            active_d <= 1'b0;
        end else begin
            hsync_d  <= raw_hsync;
            vsync_d  <= raw_vsync;
            active_d <= raw_active;
        end
    end

    // Output register, colour blanked outside the visible area
    always_ff @(posedge clk) begin
        if (reset) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            rgb   <= '0;
        end else begin
            hsync <= hsync_d;
            vsync <= vsync_d;
            de    <= active_d;
            rgb   <= active_d ? rd_data : '0;
        end
    end

endmodule

// File: rtl/vga_slave_interface.sv
`include "vga_defines.svh"

module vga_slave_interface (
    input  logic                clk,
    input  logic                reset,
    input  logic                ack,
    input  vga_bus_pkg::ctrl_t  ctrl_in,
    output logic                addr_write,
    output logic                data_we
);

    import vga_bus_pkg::*;

    slave_state_t state;
    slave_state_t next_state;
    logic         we_bit;

    assign we_bit = ctrl_in[`VGA_CTRL_WE_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_WAIT_FOR_ACK;
        end else begin
            state <= next_state;
        end
    end

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            ST_WAIT_FOR_ACK: begin
                // Strobes without the write bit are dropped here
                if (ack && we_bit) begin
                    next_state = ST_WRITE_WAIT;
                end
            end
            ST_WRITE_WAIT: begin
                next_state = ST_WRITE_DATA;
            end
            ST_WRITE_DATA: begin
                next_state = ST_FINISH;
            end
            ST_FINISH: begin
                // Hold until the master drops ack
                if (!ack) begin
                    next_state = ST_WAIT_FOR_ACK;
                end
            end
            default: begin
                next_state = ST_WAIT_FOR_ACK;
            end
        endcase
    end

    // Address latch pulse in the strobe cycle itself
    always_comb begin
        addr_write = 1'b0;
        if (state == ST_WAIT_FOR_ACK) begin
            addr_write = ack && we_bit;
        end
    end

    // Pixel data sits on bus_in two cycles after the strobe
    assign data_we = (state == ST_WRITE_DATA);

endmodule

// File: rtl/vga_timing.sv
`include "vga_defines.svh"

module vga_timing (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    raw_hsync,
    output logic                    raw_vsync,
    output logic                    raw_active,
    output vga_video_pkg::fb_addr_t rd_addr
);

    import vga_video_pkg::*;

    localparam int H_LAST       = `VGA_H_TOTAL - 1;
    localparam int V_LAST       = `VGA_V_TOTAL - 1;
    localparam int H_SYNC_START = `VGA_H_ACTIVE + `VGA_H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + `VGA_H_SYNC;
    localparam int V_SYNC_START = `VGA_V_ACTIVE + `VGA_V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + `VGA_V_SYNC;

    h_count_t h_count;
    v_count_t v_count;
    logic     line_end;

    assign line_end = (h_count == h_count_t'(H_LAST));

    // Pixel position within the line
    always_ff @(posedge clk) begin
        if (reset) begin
            h_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Line number, steps once per line
    always_ff @(posedge clk) begin
        if (reset) begin
            v_count <= '0;
        end else if (line_end) begin
            if (v_count == v_count_t'(V_LAST)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end
    end

    // Syncs are active low
    assign raw_hsync = !((h_count >= h_count_t'(H_SYNC_START)) &&
                         (h_count <  h_count_t'(H_SYNC_END)));
    assign raw_vsync = !((v_count >= v_count_t'(V_SYNC_START)) &&
                         (v_count <  v_count_t'(V_SYNC_END)));

    assign raw_active = (h_count < h_count_t'(`VGA_H_ACTIVE)) &&
                        (v_count < v_count_t'(`VGA_V_ACTIVE));

    // Same layout as the write side, y * 64 + x
    assign rd_addr = raw_active ? {v_count, h_count[5:0]} : '0;

endmodule

// File: rtl/vga_top.sv
module vga_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ack,
    input  vga_bus_pkg::ctrl_t      ctrl_in,
    input  vga_bus_pkg::bus_word_t  bus_in,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,
    output vga_video_pkg::pixel_t   rgb
);

    import vga_video_pkg::*;

    // Bus front end
    logic     addr_write;
    logic     data_we;
    logic     fb_we;
    fb_addr_t fb_waddr;
    pixel_t   fb_wdata;

    // Video pipeline
    logic     raw_hsync;
    logic     raw_vsync;
    logic     raw_active;
    fb_addr_t rd_addr;
    pixel_t   rd_data;

    vga_slave_interface u_slave_interface (
        .clk        (clk),
        .reset      (reset),
        .ack        (ack),
        .ctrl_in    (ctrl_in),
        .addr_write (addr_write),
        .data_we    (data_we)
    );

    vga_write_port u_write_port (
        .clk        (clk),
        .reset      (reset),
        .addr_write (addr_write),
        .data_we    (data_we),
        .bus_in     (bus_in),
        .fb_we      (fb_we),
        .fb_waddr   (fb_waddr),
        .fb_wdata   (fb_wdata)
    );

    vga_framebuffer u_framebuffer (
        .clk   (clk),
        .we    (fb_we),
        .waddr (fb_waddr),
        .wdata (fb_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    vga_timing u_timing (
        .clk        (clk),
        .reset      (reset),
        .raw_hsync  (raw_hsync),
        .raw_vsync  (raw_vsync),
        .raw_active (raw_active),
        .rd_addr    (rd_addr)
    );

    vga_pixel_out u_pixel_out (
        .clk        (clk),
        .reset      (reset),
        .raw_hsync  (raw_hsync),
        .raw_vsync  (raw_vsync),
        .raw_active (raw_active),
        .rd_data    (rd_data),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .rgb        (rgb)
    );

endmodule

// File: rtl/vga_video_pkg.sv
`include "vga_defines.svh"

package vga_video_pkg;

    // RGB332 pixel
    typedef logic [7:0] pixel_t;

    // x or y as carried on the bus
    typedef logic [7:0] coord_t;

    // Raster counters, sized to hold total - 1
    typedef logic [$clog2(`VGA_H_TOTAL)-1:0] h_count_t;
    typedef logic [$clog2(`VGA_V_TOTAL)-1:0] v_count_t;

    // Linear index y * 64 + x
    typedef logic [$clog2(`VGA_FB_DEPTH)-1:0] fb_addr_t;

endpackage

// File: rtl/vga_write_port.sv
`include "vga_defines.svh"

module vga_write_port (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    addr_write,
    input  logic                    data_we,
    input  vga_bus_pkg::bus_word_t  bus_in,
    output logic                    fb_we,
    output vga_video_pkg::fb_addr_t fb_waddr,
    output vga_video_pkg::pixel_t   fb_wdata
);

    import vga_video_pkg::*;

    coord_t   x_in;
    coord_t   y_in;
    fb_addr_t addr_q;
    logic     addr_valid;

    assign x_in = bus_in[`VGA_BUS_X_LSB +: 8];
    assign y_in = bus_in[`VGA_BUS_Y_LSB +: 8];

    // Latched address
    always_ff @(posedge clk) begin
        if (addr_write) begin
            // Width is a power of two, so y * 64 + x is a concatenation
            addr_q <= {y_in[5:0], x_in[5:0]};
        end
    end

    // Range flag for the latched address
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_valid <= 1'b0;
        end else if (addr_write) begin
            addr_valid <= (x_in < `VGA_H_ACTIVE) && (y_in < `VGA_V_ACTIVE);
        end
    end

    // Out-of-range writes never reach the memory
    assign fb_we    = data_we && addr_valid;
    assign fb_waddr = addr_q;
    assign fb_wdata = bus_in[`VGA_BUS_PIX_LSB +: 8];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, then judge the run from the log
verilator --binary --timing --assert --top-module tb_vga_top -f filelist.f -o vga_sim \
    > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/vga_sim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

// File: tb/tb_vga_top.sv
`include "vga_defines.svh"

module tb_vga_top;

    import vga_bus_pkg::*;
    import vga_video_pkg::*;

    localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
    localparam int FB_WORDS     = `VGA_H_ACTIVE * `VGA_V_ACTIVE;
    // About 12 frames plus room for the bus traffic
    localparam int CYCLE_LIMIT  = 12 * FRAME_CYCLES + 7040 * 4;

    logic      clk;
    logic      reset;
    logic      ack;
    ctrl_t     ctrl_in;
    bus_word_t bus_in;
    logic      hsync;
    logic      vsync;
    logic      de;
    pixel_t    rgb;

    int cycle_count;
    int checks_done;
    int error_count;
    int tests_failed;

    // Reference pixels, written mask and one captured frame
    pixel_t model_mem     [0:FB_WORDS-1];
    bit     model_written [0:FB_WORDS-1];
    pixel_t frame         [0:FB_WORDS-1];

    vga_top u_vga_top (
        .clk     (clk),
        .reset   (reset),
        .ack     (ack),
        .ctrl_in (ctrl_in),
        .bus_in  (bus_in),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .rgb     (rgb)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run hung", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
        checks_done++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s expected %02h actual %02h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks_done++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s expected %0b actual %0b", $time, name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks_done++;
        if (actual != expected) begin
            error_count++;
            $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAILED, %0d errors", name, error_count - errs_before);
        end
    endtask

    // Strobe with address, then pixel data two cycles later, 4 cycles in all
    task automatic drive_transfer(input ctrl_t ctrl, input coord_t x, input coord_t y,
                                  input pixel_t pix);
        @(posedge clk);
        ack     <= 1'b1;
        ctrl_in <= ctrl;
        bus_in  <= {16'h0, y, x};
        @(posedge clk);
        ack     <= 1'b0;
        ctrl_in <= '0;
        bus_in  <= '0;
        @(posedge clk);
        bus_in  <= {24'h0, pix};
        @(posedge clk);
        bus_in  <= '0;
    endtask

    task automatic bus_write(input coord_t x, input coord_t y, input pixel_t pix);
        int idx;
        idx = int'(y) * `VGA_H_ACTIVE + int'(x);
        // Only visible positions reach the model
        if (int'(x) < `VGA_H_ACTIVE && int'(y) < `VGA_V_ACTIVE) begin
            model_mem[idx]     = pix;
            model_written[idx] = 1'b1;
        end
        drive_transfer(ctrl_t'(1 << `VGA_CTRL_WE_BIT), x, y, pix);
    endtask

    task automatic bus_strobe_no_we(input coord_t x, input coord_t y, input pixel_t pix);
        ctrl_t ctrl;
        ctrl = ctrl_t'($urandom) & ~ctrl_t'(1 << `VGA_CTRL_WE_BIT);
        drive_transfer(ctrl, x, y, pix);
    endtask

    task automatic wait_vsync_fall();
        logic prev;
        prev = vsync;
        @(negedge clk);
        while (!(prev && !vsync)) begin
            prev = vsync;
            @(negedge clk);
        end
    endtask

    // Raster monitor, x from the start of each de run and y from the runs after vsync
    task automatic capture_frame();
        int x;
        int y;
        wait_vsync_fall();
        while (!vsync) @(negedge clk);
        for (y = 0; y < `VGA_V_ACTIVE; y++) begin
            while (!de) @(negedge clk);
            for (x = 0; x < `VGA_H_ACTIVE; x++) begin
                check_bit("de", 1'b1, de);
                frame[y * `VGA_H_ACTIVE + x] = rgb;
                @(negedge clk);
            end
        end
    endtask

    task automatic compare_frame();
        int idx;
        for (idx = 0; idx < FB_WORDS; idx++) begin
            if (model_written[idx]) begin
                check_pixel($sformatf("rgb(x=%0d,y=%0d)", idx % `VGA_H_ACTIVE,
                            idx / `VGA_H_ACTIVE), model_mem[idx], frame[idx]);
            end
        end
    endtask

    task automatic test_reset_state();
        int errs_before;
        int i;
        errs_before = error_count;
        for (i = 0; i <= 16; i++) begin
            // The last pass samples the first cycle the DUT runs out of reset
            if (i == 16) begin
                @(posedge clk);
                reset <= 1'b0;
                @(posedge clk);
            end
            @(negedge clk);
            check_bit("hsync", 1'b1, hsync);
            check_bit("vsync", 1'b1, vsync);
            check_bit("de", 1'b0, de);
            check_pixel("rgb", '0, rgb);
        end
        report_test("reset state", errs_before);
    endtask

    task automatic test_raster();
        int   errs_before;
        int   frame_start;
        int   last_hfall;
        int   hs_low;
        int   vs_low;
        int   de_run;
        int   active_lines;
        logic hs_prev;
        logic vs_prev;
        logic de_prev;
        logic done;
        errs_before  = error_count;
        last_hfall   = -1;
        hs_low       = 0;
        vs_low       = 0;
        de_run       = 0;
        active_lines = 0;
        done         = 1'b0;
        // Non-zero corner pixels, so unblanked colour would show in the porches
        bus_write(8'd0, 8'd0, 8'hff);
        bus_write(8'd63, 8'd47, 8'hff);
        wait_vsync_fall();
        frame_start = cycle_count;
        hs_prev = hsync;
        vs_prev = vsync;
        de_prev = de;
        while (!done) begin
            if (!vsync) vs_low++;
            if (!hsync) hs_low++;
            if (de) de_run++;
            if (!de) check_pixel("rgb outside de", '0, rgb);
            @(negedge clk);
            if (hs_prev && !hsync) begin
                if (last_hfall >= 0) begin
                    check_count("line period", `VGA_H_TOTAL, cycle_count - last_hfall);
                end
                last_hfall = cycle_count;
            end
            if (!hs_prev && hsync) begin
                check_count("hsync low length", `VGA_H_SYNC, hs_low);
                hs_low = 0;
            end
            if (de_prev && !de) begin
                check_count("de run length", `VGA_H_ACTIVE, de_run);
                de_run = 0;
                active_lines++;
            end
            done    = vs_prev && !vsync;
            hs_prev = hsync;
            vs_prev = vsync;
            de_prev = de;
        end
        check_count("frame period", FRAME_CYCLES, cycle_count - frame_start);
        check_count("vsync low length", `VGA_V_SYNC * `VGA_H_TOTAL, vs_low);
        check_count("active lines", `VGA_V_ACTIVE, active_lines);
        report_test("raster timing", errs_before);
    endtask

    task automatic test_write_display();
        int errs_before;
        errs_before = error_count;
        repeat (200) begin
            bus_write(coord_t'($urandom % 64), coord_t'($urandom % 48), pixel_t'($urandom));
        end
        capture_frame();
        compare_frame();
        report_test("write and display", errs_before);
    endtask

    task automatic test_ignored_strobes();
        int errs_before;
        int n;
        int idx;
        errs_before = error_count;
        for (n = 0; n < 16; n++) begin
            idx = int'($urandom % FB_WORDS);
            while (!model_written[idx]) idx = (idx + 1) % FB_WORDS;
            bus_strobe_no_we(coord_t'(idx % 64), coord_t'(idx / 64), ~model_mem[idx]);
        end
        capture_frame();
        compare_frame();
        report_test("ignored strobes", errs_before);
    endtask

    task automatic test_range_check();
        int     errs_before;
        int     n;
        coord_t x;
        coord_t y;
        errs_before = error_count;
        for (n = 0; n < 8; n++) begin
            x = coord_t'($urandom % 64);
            y = coord_t'($urandom % 48);
            bus_write(x, y, pixel_t'($urandom));
            // Each of these lands on (x, y) if the low 6 bits were used unchecked
            bus_write(x + 8'd64, y, ~model_mem[int'(y) * 64 + int'(x)]);
            bus_write(x, y + 8'd64, ~model_mem[int'(y) * 64 + int'(x)]);
            bus_write(x + 8'd128, y + 8'd192, ~model_mem[int'(y) * 64 + int'(x)]);
        end
        capture_frame();
        compare_frame();
        report_test("range check", errs_before);
    endtask

    task automatic test_back_to_back();
        int     errs_before;
        int     n;
        int     k;
        coord_t xs [0:5];
        coord_t ys [0:5];
        errs_before = error_count;
        xs[0] = 8'd0;
        ys[0] = 8'd0;
        xs[1] = 8'd63;
        ys[1] = 8'd47;
        for (n = 2; n < 6; n++) begin
            xs[n] = coord_t'($urandom % 64);
            ys[n] = coord_t'($urandom % 48);
        end
        for (n = 0; n < 36; n++) begin
            k = int'($urandom % 6);
            bus_write(xs[k], ys[k], pixel_t'($urandom));
        end
        capture_frame();
        compare_frame();
        report_test("back-to-back", errs_before);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ack          = 1'b0;
        ctrl_in      = '0;
        bus_in       = '0;
        cycle_count  = 0;
        checks_done  = 0;
        error_count  = 0;
        tests_failed = 0;
        void'($urandom(32'hba12_ba40));
        test_reset_state();
        test_raster();
        test_write_display();
        test_ignored_strobes();
        test_range_check();
        test_back_to_back();
        $display("Tests failed: %0d of 6, checks: %0d, errors: %0d",
                 tests_failed, checks_done, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb/vga_assert.sv
module vga_assert (
    input logic clk,
    input logic reset,
    input logic addr_write,
    input logic data_we,
    input logic hsync,
    input logic vsync,
    input logic de
);

    // Address latch and data write of one strobe never share a cycle
    no_overlap: assert property (
        @(posedge clk) disable iff (reset) !(addr_write && data_we)
    ) else $error("addr_write and data_we high in the same cycle");

    // Every accepted strobe gives a data pulse two cycles later
    data_after_addr: assert property (
        @(posedge clk) disable iff (reset) $past(addr_write, 2) |-> data_we
    ) else $error("data_we missing two cycles after addr_write");

    // and no data pulse appears without one
    addr_before_data: assert property (
        @(posedge clk) disable iff (reset) data_we |-> $past(addr_write, 2)
    ) else $error("data_we without addr_write two cycles before");

    // Visible area lies outside both sync pulses
    de_outside_sync: assert property (
        @(posedge clk) disable iff (reset) de |-> (hsync && vsync)
    ) else $error("de high during a sync pulse");

endmodule

bind vga_top vga_assert u_vga_assert (
    .clk        (clk),
    .reset      (reset),
    .addr_write (addr_write),
    .data_we    (data_we),
    .hsync      (hsync),
    .vsync      (vsync),
    .de         (de)
);
